/* dv/conv_accel_tb.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_accel_tb;
    import conv_ctrl_pkg::*;
    import conv_data_pkg::*;

    localparam int NUM_CASES = 5;
    localparam int MEM_WORDS = 65536;
    localparam int DRIVE_DELAY = 2;
    localparam int KERNEL_PTR = 'h0200;
    localparam int SRC_PTR = 'h1000;
    localparam int DST_PTR = 'h8000;

    typedef enum logic [1:0] {
        KERN_IDENTITY,
        KERN_SMALL,         // -8 .. 7
        KERN_WIDE           // full range, sums wrap
    } kern_mode_e;

    typedef struct packed {
        logic [`CONV_RES_W-1:0] xres;
        logic [`CONV_RES_W-1:0] yres;
        logic                   pad;
        kern_mode_e             kern;
        logic [15:0]            seed;           // source fill
        logic                   dst_random;     // zero preload otherwise
    } case_t;

    case_t cases [NUM_CASES] = '{
        '{7'd5,  7'd5, 1'b0, KERN_IDENTITY, 16'h0011, 1'b0},
        '{7'd6,  7'd5, 1'b1, KERN_SMALL,    16'h0203, 1'b0},
        '{7'd7,  7'd4, 1'b1, KERN_WIDE,     16'h3a5c, 1'b1},
        '{7'd64, 7'd4, 1'b0, KERN_SMALL,    16'h7e01, 1'b1},   // full line buffer
        '{7'd9,  7'd6, 1'b1, KERN_WIDE,     16'hc0de, 1'b1}    // follows at once
    };

    logic                      clock;
    logic                      clock_sreset;
    logic [`CONV_CSR_AW-1:0]   s_address;
    logic [`CONV_CSR_DW-1:0]   s_writedata;
    logic [`CONV_CSR_DW-1:0]   s_readdata;
    logic                      s_read;
    logic                      s_write;
    logic                      s_waitrequest;
    logic [`CONV_ADDR_W-1:0]   m_address;
    logic [`CONV_SAMPLE_W-1:0] m_readdata;
    logic [`CONV_SAMPLE_W-1:0] m_writedata;
    logic [`CONV_BE_W-1:0]     m_byteenable;
    logic                      m_read;
    logic                      m_write;
    logic                      m_waitrequest;
    logic [`CONV_SAMPLE_W-1:0] shadow [MEM_WORDS];     // expected memory contents
    sample_t                   kern [`CONV_TAPS];
    int                        cycles = 0;
    int                        cycle_limit;
    int                        case_idx;

    conv_accel u_dut (
        .clock, .clock_sreset,
        .s_address, .s_writedata, .s_readdata, .s_read, .s_write, .s_waitrequest,
        .m_address, .m_readdata, .m_writedata, .m_byteenable, .m_read, .m_write,
        .m_waitrequest
    );

    conv_mem_model u_mem (
        .clock, .clock_sreset,
        .address(m_address), .writedata(m_writedata), .byteenable(m_byteenable),
        .read(m_read), .write(m_write), .readdata(m_readdata), .waitrequest(m_waitrequest)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display(">>> FAIL");
            $fatal(1, "timeout: the runs did not finish within %0d clock cycles", cycle_limit);
        end
    end

    //////////////////////////////
    function automatic logic [15:0] fill_value(input int seed, input int idx);
        logic [31:0] h;
        h = seed * 32'h9e3779b1 ^ idx * 32'h85ebca6b;
        return h[31:16] ^ h[15:0];
    endfunction

    function automatic int out_width(input case_t c);
        return c.xres + 2 * c.pad - 2;
    endfunction

    function automatic int out_height(input case_t c);
        return c.yres + 2 * c.pad - 2;
    endfunction

    // zero outside the source image
    function automatic sample_t padded_pixel(input case_t c, input int px, input int py);
        int pw;
        int ph;
        pw = c.xres + 2 * c.pad;
        ph = c.yres + 2 * c.pad;
        if (c.pad && (px == 0 || py == 0 || px == pw - 1 || py == ph - 1)) begin
            return '0;
        end
        return sample_t'(shadow[SRC_PTR / 2 + (py - c.pad) * c.xres + px - c.pad]);
    endfunction

    task automatic check_sample(input sample_t got, input sample_t exp, input int x, input int y);
        if (got !== exp) begin
            if (y < 0) begin
                $display("** Error at %0t: case %0d stray write at word 0x%h, got %0d expected %0d",
                         $time, case_idx, x, got, exp);
            end else begin
                $display("** Error at %0t: case %0d pixel (%0d,%0d) got %0d expected %0d",
                         $time, case_idx, x, y, got, exp);
            end
            $display(">>> FAIL");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_cfg_word(input string what, input logic [`CONV_CSR_DW-1:0] got,
                                  input logic [`CONV_CSR_DW-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: case %0d %s read 0x%h expected 0x%h",
                     $time, case_idx, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "register mismatch");
        end
    endtask

    //////////////////////////////
    // called DRIVE_DELAY after a rising edge, return the same way
    task automatic csr_write(input csr_addr_e addr, input logic [`CONV_CSR_DW-1:0] data);
        s_address = addr;
        s_writedata = data;
        s_write = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        s_write = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_e addr, output logic [`CONV_CSR_DW-1:0] data);
        logic done;
        done = 1'b0;
        s_address = addr;
        s_read = 1'b1;
        while (!done) begin
            @(negedge clock);
            if (!s_waitrequest) begin
                data = s_readdata;
                done = 1'b1;
            end
            @(posedge clock);
            #DRIVE_DELAY;
        end
        s_read = 1'b0;
    endtask

    task automatic load_case(input case_t c);
        for (int i = 0; i < `CONV_TAPS; i++) begin
            case (c.kern)
                KERN_IDENTITY: kern[i] = (i == `CONV_TAPS / 2) ? 16'sd1 : 16'sd0;
                KERN_SMALL:    kern[i] = sample_t'($signed(4'($urandom)));
                default:       kern[i] = sample_t'($urandom);
            endcase
            shadow[KERNEL_PTR / 2 + i] = kern[i];
        end
        for (int i = 0; i < c.xres * c.yres; i++) begin
            shadow[SRC_PTR / 2 + i] = fill_value(c.seed, SRC_PTR / 2 + i);
        end
        for (int i = 0; i < out_width(c) * out_height(c); i++) begin
            shadow[DST_PTR / 2 + i] = c.dst_random ? 16'($urandom) : 16'h0000;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_mem.mem[i] = shadow[i];
        end
    endtask

    // destination plus window sum, low 16 bits
    task automatic predict_case(input case_t c);
        acc_t acc;
        int   idx;
        for (int oy = 0; oy < out_height(c); oy++) begin
            for (int ox = 0; ox < out_width(c); ox++) begin
                acc = '0;
                for (int t = 0; t < `CONV_TAPS; t++) begin
                    acc += acc_t'(kern[t]) *
                           acc_t'(padded_pixel(c, ox + t % `CONV_K, oy + t / `CONV_K));
                end
                idx = DST_PTR / 2 + oy * out_width(c) + ox;
                shadow[idx] = shadow[idx] + acc[`CONV_SAMPLE_W-1:0];
            end
        end
    endtask

    task automatic compare_memory(input case_t c);
        int rel;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rel = i - DST_PTR / 2;
            if (rel >= 0 && rel < out_width(c) * out_height(c)) begin
                check_sample(u_mem.mem[i], shadow[i], rel % out_width(c), rel / out_width(c));
            end else begin
                check_sample(u_mem.mem[i], shadow[i], i, -1);
            end
        end
    endtask

    task automatic run_case(input case_t c);
        csr_addr_e               regs [6];
        logic [`CONV_CSR_DW-1:0] vals [6];
        logic [`CONV_CSR_DW-1:0] rd;
        regs = '{REG_KERNEL, REG_SOURCE, REG_DEST, REG_XRES, REG_YRES, REG_PAD};
        vals = '{KERNEL_PTR, SRC_PTR, DST_PTR, c.xres, c.yres, c.pad};
        load_case(c);
        foreach (regs[k]) begin
            csr_write(regs[k], vals[k]);
        end
        foreach (regs[k]) begin
            csr_read(regs[k], rd);
            check_cfg_word(regs[k].name(), rd, vals[k]);
        end
        csr_write(REG_CTRL, 32'h1);
        csr_read(REG_CTRL, rd);
        check_cfg_word("busy during run", rd, 32'h2);
        while (rd[1]) begin
            csr_read(REG_CTRL, rd);
        end
        predict_case(c);
        compare_memory(c);
    endtask

    //////////////////////////////
    initial begin
        logic [`CONV_CSR_DW-1:0] rd;
        void'($urandom(87773));
        clock_sreset = 1'b1;
        s_address = REG_CTRL;
        s_writedata = '0;
        s_read = 1'b0;
        s_write = 1'b0;
        case_idx = 0;
        cycle_limit = 2000;
        foreach (cases[n]) begin
            cycle_limit += 20 * out_width(cases[n]) * out_height(cases[n]);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_value(0, i);   // background outside every image
        end
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
        clock_sreset = 1'b0;
        csr_read(REG_CTRL, rd);
        check_cfg_word("busy after reset", rd, '0);
        for (case_idx = 0; case_idx < NUM_CASES; case_idx++) begin
            run_case(cases[case_idx]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/conv_mem_model.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_mem_model (
    input  wire                        clock,
    input  wire                        clock_sreset,
    input  wire [`CONV_ADDR_W-1:0]     address,
    input  wire [`CONV_SAMPLE_W-1:0]   writedata,
    input  wire [`CONV_BE_W-1:0]       byteenable,
    input  wire                        read,
    input  wire                        write,
    output logic [`CONV_SAMPLE_W-1:0]  readdata,
    output logic                       waitrequest
);
    localparam int WORDS = 65536;

    logic [`CONV_SAMPLE_W-1:0] mem [WORDS];     // loaded by the testbench
    logic [15:0]               word;
    logic                      stall;

    assign word = address[16:1];                // 2 bytes per word
    assign readdata = mem[word];
    assign waitrequest = stall & (read | write);

    // about three cycles in eight stall
    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            stall <= 1'b0;
        end else begin
            stall <= ($urandom % 8) < 3;
        end
    end

    //////////////////////////////
    always @(posedge clock) begin
        if (write && !waitrequest) begin
            for (int b = 0; b < `CONV_BE_W; b++) begin
                if (byteenable[b]) begin
                    mem[word][b*8 +: 8] <= writedata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* include/conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// kernel geometry
`define CONV_K          3
`define CONV_TAPS       9

// image limits
`define CONV_MAX_XRES   64      // line buffer depth
`define CONV_RES_W      7       // xres / yres register width

// datapath
`define CONV_SAMPLE_W   16
`define CONV_ACC_W      32      // products and sums

// master port
`define CONV_ADDR_W     32
`define CONV_BE_W       2       // bytes per sample

// register slave port
`define CONV_CSR_AW     4
`define CONV_CSR_DW     32

`endif

/* project.f */
+incdir+include
rtl/conv_ctrl_pkg.sv
rtl/conv_data_pkg.sv
rtl/conv_csr.sv
rtl/conv_window.sv
rtl/conv_mac.sv
rtl/conv_sequencer.sv
rtl/conv_accel.sv
dv/conv_mem_model.sv
dv/conv_accel_tb.sv

/* rtl/conv_accel.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_accel (
    input  wire                          clock,
    input  wire                          clock_sreset,
    input  wire [`CONV_CSR_AW-1:0]       s_address,
    input  wire [`CONV_CSR_DW-1:0]       s_writedata,
    output logic [`CONV_CSR_DW-1:0]      s_readdata,
    input  wire                          s_read,
    input  wire                          s_write,
    output logic                         s_waitrequest,
    output logic [`CONV_ADDR_W-1:0]      m_address,
    input  wire [`CONV_SAMPLE_W-1:0]     m_readdata,
    output logic [`CONV_SAMPLE_W-1:0]    m_writedata,
    output logic [`CONV_BE_W-1:0]        m_byteenable,
    output logic                         m_read,
    output logic                         m_write,
    input  wire                          m_waitrequest
);
    import conv_ctrl_pkg::*;
    import conv_data_pkg::*;

    conv_cfg_t            cfg;
    mem_req_t             mem_req;
    window_t              window;
    sample_t              kernel_sample;
    sample_t              pixel;
    acc_t                 sum;
    logic [`CONV_RES_W:0] line_width;
    logic                 go;
    logic                 busy;
    logic                 kernel_load;
    logic                 pixel_push;
    logic                 start;
    logic                 window_valid;
    logic                 sum_valid;

    //////////////////////////////
    conv_csr u_csr (
        .clock, .clock_sreset,
        .s_address, .s_writedata, .s_read, .s_write, .s_readdata, .s_waitrequest,
        .busy, .cfg, .go
    );

    conv_sequencer u_seq (
        .clock, .clock_sreset, .cfg, .go, .busy, .mem_req, .m_readdata, .m_waitrequest,
        .kernel_load, .kernel_sample, .pixel_push, .pixel, .line_width, .start,
        .window_valid, .sum_valid, .sum
    );

    conv_window u_window (
        .clock, .clock_sreset, .pixel_push, .pixel, .line_width, .start,
        .window_valid, .window
    );

    conv_mac u_mac (
        .clock, .clock_sreset, .kernel_load, .kernel_sample, .window_valid, .window,
        .sum_valid, .sum
    );

    // master port
    assign m_address = mem_req.address;
    assign m_writedata = mem_req.writedata;
    assign m_read = mem_req.read;
    assign m_write = mem_req.write;
    assign m_byteenable = '1;       // whole samples only

endmodule

`default_nettype wire

/* rtl/conv_csr.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_csr (
    input  wire                          clock,
    input  wire                          clock_sreset,
    input  wire [`CONV_CSR_AW-1:0]       s_address,
    input  wire [`CONV_CSR_DW-1:0]       s_writedata,
    input  wire                          s_read,
    input  wire                          s_write,
    output logic [`CONV_CSR_DW-1:0]      s_readdata,
    output logic                         s_waitrequest,
    input  wire                          busy,
    output conv_ctrl_pkg::conv_cfg_t     cfg,
    output logic                         go
);
    import conv_ctrl_pkg::*;

    csr_addr_e addr;
    logic      read_latency;    // second cycle of a read

    assign addr = csr_addr_e'(s_address);
    assign s_waitrequest = s_read & ~read_latency;

    //////////////////////////////
    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            read_latency <= 1'b0;
            go <= 1'b0;
            cfg <= '0;
        end else begin
            read_latency <= s_read & ~read_latency;
            go <= s_write && addr == REG_CTRL && s_writedata[0] && !busy;
            if (s_write) begin
                case (addr)
                    REG_KERNEL: cfg.kernel_ptr <= s_writedata;
                    REG_SOURCE: cfg.src_ptr <= s_writedata;
                    REG_DEST:   cfg.dst_ptr <= s_writedata;
                    REG_XRES:   cfg.xres <= s_writedata[`CONV_RES_W-1:0];
                    REG_YRES:   cfg.yres <= s_writedata[`CONV_RES_W-1:0];
                    REG_PAD:    cfg.pad <= s_writedata[0];
                    default: ;
                endcase
            end
        end
    end

    // captured in the first read cycle, held while waitrequest drops
    always_ff @(posedge clock) begin
        case (addr)
            REG_CTRL:   s_readdata <= `CONV_CSR_DW'({busy, 1'b0});
            REG_KERNEL: s_readdata <= cfg.kernel_ptr;
            REG_SOURCE: s_readdata <= cfg.src_ptr;
            REG_DEST:   s_readdata <= cfg.dst_ptr;
            REG_XRES:   s_readdata <= `CONV_CSR_DW'(cfg.xres);
            REG_YRES:   s_readdata <= `CONV_CSR_DW'(cfg.yres);
            REG_PAD:    s_readdata <= `CONV_CSR_DW'(cfg.pad);
            default:    s_readdata <= '0;
        endcase
    end

    //////////////////////////////
    // an accepted go starts a run, so a second go cannot follow it
    a_go_starts_run: assert property (@(posedge clock) disable iff (clock_sreset)
        go |=> busy && !go);

endmodule

`default_nettype wire

/* rtl/conv_ctrl_pkg.sv */
`default_nettype none

`include "conv_consts.svh"

package conv_ctrl_pkg;

    typedef enum logic [`CONV_CSR_AW-1:0] {
        REG_CTRL   = 4'd0,      // bit 0 go, bit 1 busy
        REG_KERNEL = 4'd2,
        REG_SOURCE = 4'd3,
        REG_DEST   = 4'd4,
        REG_XRES   = 4'd5,
        REG_YRES   = 4'd6,
        REG_PAD    = 4'd8
    } csr_addr_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_KERNEL,
        ST_FEED,                // pixel or pad into the window
        ST_WAIT_WIN,
        ST_WAIT_MAC,
        ST_READ_DST,
        ST_WRITE_DST
    } seq_state_e;

    typedef struct packed {
        logic [`CONV_ADDR_W-1:0] kernel_ptr;
        logic [`CONV_ADDR_W-1:0] src_ptr;
        logic [`CONV_ADDR_W-1:0] dst_ptr;
        logic [`CONV_RES_W-1:0]  xres;      // without padding
        logic [`CONV_RES_W-1:0]  yres;
        logic                    pad;
    } conv_cfg_t;

endpackage

`default_nettype wire

/* rtl/conv_data_pkg.sv */
`default_nettype none

`include "conv_consts.svh"

package conv_data_pkg;

    typedef logic signed [`CONV_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`CONV_ACC_W-1:0]    acc_t;
    typedef logic signed [`CONV_ACC_W-1:0]    prod_t;

    // tap 0 is top-left, row-major
    typedef struct packed {
        sample_t [`CONV_TAPS-1:0] tap;
    } window_t;

    typedef struct packed {
        logic [`CONV_ADDR_W-1:0]   address;
        logic [`CONV_SAMPLE_W-1:0] writedata;
        logic                      read;
        logic                      write;
    } mem_req_t;

endpackage

`default_nettype wire

/* rtl/conv_mac.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_mac (
    input  wire                          clock,
    input  wire                          clock_sreset,
    input  wire                          kernel_load,
    input  wire conv_data_pkg::sample_t  kernel_sample,
    input  wire                          window_valid,
    input  wire conv_data_pkg::window_t  window,
    output logic                         sum_valid,
    output conv_data_pkg::acc_t          sum
);
    import conv_data_pkg::*;

    sample_t    weight [`CONV_TAPS];
    prod_t      prod [`CONV_TAPS];
    acc_t       row_sum [`CONV_K];
    logic [2:0] stage_vld;      // one bit per pipeline stage

    // first loaded sample ends up at tap 0
    always_ff @(posedge clock) begin
        if (kernel_load) begin
            for (int k = 0; k < `CONV_TAPS - 1; k++) begin
                weight[k] <= weight[k+1];
            end
            weight[`CONV_TAPS-1] <= kernel_sample;
        end
    end

    //////////////////////////////
    always_ff @(posedge clock) begin
        if (window_valid) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                prod[i] <= prod_t'(window.tap[i]) * prod_t'(weight[i]);
            end
        end
        if (stage_vld[0]) begin
            for (int r = 0; r < `CONV_K; r++) begin
                row_sum[r] <= prod[r*`CONV_K] + prod[r*`CONV_K+1] + prod[r*`CONV_K+2];
            end
        end
        if (stage_vld[1]) begin
            sum <= row_sum[0] + row_sum[1] + row_sum[2];
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            stage_vld <= '0;
        end else begin
            stage_vld <= {stage_vld[1:0], window_valid};
        end
    end

    assign sum_valid = stage_vld[2];

endmodule

`default_nettype wire

/* rtl/conv_sequencer.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_sequencer (
    input  wire                          clock,
    input  wire                          clock_sreset,
    input  wire conv_ctrl_pkg::conv_cfg_t cfg,
    input  wire                          go,
    output logic                         busy,
    output conv_data_pkg::mem_req_t      mem_req,
    input  wire [`CONV_SAMPLE_W-1:0]     m_readdata,
    input  wire                          m_waitrequest,
    output logic                         kernel_load,
    output conv_data_pkg::sample_t       kernel_sample,
    output logic                         pixel_push,
    output conv_data_pkg::sample_t       pixel,
    output logic [`CONV_RES_W:0]         line_width,
    output logic                         start,
    input  wire                          window_valid,
    input  wire                          sum_valid,
    input  wire conv_data_pkg::acc_t     sum
);
    import conv_ctrl_pkg::*;
    import conv_data_pkg::*;

    localparam int PW = `CONV_RES_W + 1;

    seq_state_e              state;
    logic [PW-1:0]           pad_w;         // padded image size
    logic [PW-1:0]           pad_h;
    logic [PW-1:0]           fx;            // feed position
    logic [PW-1:0]           fy;
    logic [3:0]              tap_cnt;
    logic [`CONV_ADDR_W-1:0] src_addr;
    logic [`CONV_ADDR_W-1:0] dst_addr;
    logic                    is_pad;
    logic                    accepted;
    logic                    last_win;
    acc_t                    sum_q;

    assign pad_w = PW'(cfg.xres) + PW'({cfg.pad, 1'b0});
    assign pad_h = PW'(cfg.yres) + PW'({cfg.pad, 1'b0});
    assign line_width = pad_w;
    assign is_pad = cfg.pad && (fx == 0 || fx == pad_w - 1'b1 ||
                                fy == 0 || fy == pad_h - 1'b1);
    assign accepted = (mem_req.read || mem_req.write) && !m_waitrequest;

    assign busy = go || state != ST_IDLE;
    assign start = go && state == ST_IDLE;
    assign kernel_load = state == ST_KERNEL && accepted;
    assign kernel_sample = sample_t'(m_readdata);
    assign pixel_push = state == ST_FEED && (is_pad || accepted);
    assign pixel = is_pad ? '0 : sample_t'(m_readdata);     // pad pushed as zero

    //////////////////////////////
    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= ST_IDLE;
            mem_req.read <= 1'b0;
            mem_req.write <= 1'b0;
            tap_cnt <= '0;
            fx <= '0;
            fy <= '0;
            last_win <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        mem_req.address <= cfg.kernel_ptr;
                        mem_req.read <= 1'b1;
                        tap_cnt <= '0;
                        fx <= '0;
                        fy <= '0;
                        src_addr <= cfg.src_ptr;
                        dst_addr <= cfg.dst_ptr;
                        state <= ST_KERNEL;
                    end
                end
                ST_KERNEL: begin
                    if (accepted) begin
                        mem_req.address <= mem_req.address + `CONV_BE_W;
                        tap_cnt <= tap_cnt + 1'b1;
                        if (tap_cnt == `CONV_TAPS - 1) begin
                            mem_req.read <= 1'b0;
                            state <= ST_FEED;
                        end
                    end
                end
                ST_FEED: begin
                    if (pixel_push) begin
                        mem_req.read <= 1'b0;
                        if (!is_pad) begin
                            src_addr <= src_addr + `CONV_BE_W;
                        end
                        last_win <= fx == pad_w - 1'b1 && fy == pad_h - 1'b1;
                        if (fx == pad_w - 1'b1) begin
                            fx <= '0;
                            fy <= fy + 1'b1;
                        end else begin
                            fx <= fx + 1'b1;
                        end
                        if (fx >= 2 && fy >= 2) begin      // this push completes a window
                            state <= ST_WAIT_WIN;
                        end
                    end else if (!mem_req.read) begin
                        mem_req.address <= src_addr;
                        mem_req.read <= 1'b1;
                    end
                end
                ST_WAIT_WIN: begin
                    if (window_valid) begin
                        state <= ST_WAIT_MAC;
                    end
                end
                ST_WAIT_MAC: begin
                    if (sum_valid) begin
                        sum_q <= sum;
                        mem_req.address <= dst_addr;
                        mem_req.read <= 1'b1;
                        state <= ST_READ_DST;
                    end
                end
                ST_READ_DST: begin
                    if (accepted) begin
                        mem_req.read <= 1'b0;
                        mem_req.write <= 1'b1;
                        mem_req.writedata <= m_readdata + sum_q[`CONV_SAMPLE_W-1:0];  // wraps
                        state <= ST_WRITE_DST;
                    end
                end
                ST_WRITE_DST: begin
                    if (accepted) begin
                        mem_req.write <= 1'b0;
                        dst_addr <= dst_addr + `CONV_BE_W;
                        state <= last_win ? ST_IDLE : ST_FEED;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    a_one_request: assert property (@(posedge clock) disable iff (clock_sreset)
        !(mem_req.read && mem_req.write));

    a_hold_request: assert property (@(posedge clock) disable iff (clock_sreset)
        (mem_req.read || mem_req.write) && m_waitrequest |=> $stable(mem_req));

endmodule

`default_nettype wire

/* rtl/conv_window.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_window (
    input  wire                         clock,
    input  wire                         clock_sreset,
    input  wire                         pixel_push,
    input  wire conv_data_pkg::sample_t pixel,
    input  wire [`CONV_RES_W:0]         line_width,
    input  wire                         start,
    output logic                        window_valid,
    output conv_data_pkg::window_t      window
);
    import conv_data_pkg::*;

    localparam int COL_W = $clog2(`CONV_MAX_XRES);

    sample_t              line_top [`CONV_MAX_XRES];  // two rows up
    sample_t              line_mid [`CONV_MAX_XRES];  // one row up
    sample_t              top_px;
    sample_t              mid_px;
    logic [`CONV_RES_W:0] col;
    logic [`CONV_RES_W:0] row;

    assign top_px = line_top[col[COL_W-1:0]];
    assign mid_px = line_mid[col[COL_W-1:0]];

    //////////////////////////////
    // line buffers and shift window
    always_ff @(posedge clock) begin
        if (pixel_push) begin
            line_top[col[COL_W-1:0]] <= mid_px;
            line_mid[col[COL_W-1:0]] <= pixel;
            for (int r = 0; r < `CONV_K; r++) begin
                for (int c = 0; c < `CONV_K - 1; c++) begin
                    window.tap[r*`CONV_K+c] <= window.tap[r*`CONV_K+c+1];
                end
            end
            window.tap[`CONV_K-1]   <= top_px;     // new right column
            window.tap[2*`CONV_K-1] <= mid_px;
            window.tap[3*`CONV_K-1] <= pixel;
        end
    end

    //////////////////////////////
    // position in the padded image
    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            col <= '0;
            row <= '0;
            window_valid <= 1'b0;
        end else begin
            window_valid <= pixel_push && row >= 2 && col >= 2;
            if (start) begin
                col <= '0;
                row <= '0;
            end else if (pixel_push) begin
                if (col == line_width - 1'b1) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    a_line_fits: assert property (@(posedge clock) disable iff (clock_sreset)
        pixel_push |-> line_width <= `CONV_MAX_XRES);

endmodule

`default_nettype wire
